// ==== design/mni_pkt_pkg.sv ====
package mni_pkt_pkg;

  // ====================================================================
  // Packet sequencing
  // ====================================================================

  // Header walk of the write and read packets
  typedef enum logic [4:0] {
    Idle,
    WrOpcode,
    WrDstNode,
    WrDstAdrHigh,
    WrDstAdrLow,
    WrAckNode,
    WrAckAdrHigh,
    WrAckAdrLow,
    WrPayload,
    RdOpcode,
    RdDstNode,
    RdDstAdrHigh,
    RdDstAdrLow,
    RdSrcNode,
    RdSrcAdrHigh,
    RdSrcAdrLow,
    RdSizeHigh,
    RdSizeLow
  } pkt_state_e;

  // Opcode kind field, bits 15:14 of the opcode word
  typedef enum logic [1:0] {
    KIND_WRITE = 2'b00,
    KIND_READ  = 2'b01
  } pkt_kind_e;

  // ====================================================================
  // Sizes and field constants
  // ====================================================================
  localparam int WORD_W = 16;
  localparam int OFS_W  = 6;

  localparam logic [3:0] DST_NODE_TAG = 4'hC;

  // Payload placement and lengths in words
  localparam int PAYLOAD_OFS   = 7;
  localparam int LINE_WORDS    = 32;
  localparam int SHORT_WORDS   = 2;
  localparam int RD_SIZE_WORDS = 5;

  // Read size field, in bytes
  localparam int LINE_BYTES  = 64;
  localparam int SHORT_BYTES = 4;

  // Source command word fields
  localparam int CMD_WRITE_BIT = 4;
  localparam int CMD_LINE_BIT  = 14;
  localparam int CMD_BE_HI     = 8;
  localparam int CMD_BE_LO     = 5;

endpackage

// ==== design/mni_port_pkg.sv ====
package mni_port_pkg;

  import mni_pkt_pkg::*;

  // Request sources, index order is also priority order
  typedef enum logic [1:0] {
    SRC_MISS = 2'd0,
    SRC_WB   = 2'd1,
    SRC_ACK  = 2'd2
  } src_id_e;

  localparam int N_SRC = 3;

  // One-hot virtual channel
  typedef logic [2:0] vc_t;

  localparam vc_t VC_ACK   = 3'b001;
  localparam vc_t VC_WRITE = 3'b010;
  localparam vc_t VC_READ  = 3'b100;

  // ====================================================================
  // Port structs
  // ====================================================================
  typedef struct packed {
    logic              valid;
    logic [WORD_W-1:0] data;
  } src_req_t;

  typedef struct packed {
    pkt_kind_e                    kind;
    vc_t                          vc;
    logic                         has_ack;
    logic                         line_size;
    logic                         from_miss;
    logic [CMD_BE_HI-CMD_BE_LO:0] be;
  } pkt_desc_t;

  typedef struct packed {
    vc_t              enq;
    logic [OFS_W-1:0] offset;
    logic             eop;
    logic [WORD_W-1:0] data;
  } nout_word_t;

endpackage

// ==== design/src_arbiter.sv ====
`timescale 1ns/1ps

module src_arbiter
  import mni_pkt_pkg::*;
  import mni_port_pkg::*;
(
  input  logic     clk_ni,
  input  logic     rst_ni,
  input  logic     i_idle,
  input  src_req_t i_req [N_SRC],
  input  vc_t      i_nout_full,
  output logic     o_grant_valid,
  output src_id_e  o_grant,
  output logic     o_is_read
);

  logic [N_SRC-1:0] elig;
  logic             valid_d;
  logic             valid_q;
  src_id_e          grant_d;
  src_id_e          grant_q;
  logic             is_read_d;
  logic             is_read_q;

  // Eligibility, a miss targets VC1 for writes and VC2 for reads
  always_comb begin
    elig[SRC_MISS] = i_req[SRC_MISS].valid &
                     (i_req[SRC_MISS].data[CMD_WRITE_BIT] ? ~|(i_nout_full & VC_WRITE)
                                                          : ~|(i_nout_full & VC_READ));
    elig[SRC_WB]   = i_req[SRC_WB].valid  & ~|(i_nout_full & VC_WRITE);
    elig[SRC_ACK]  = i_req[SRC_ACK].valid & ~|(i_nout_full & VC_ACK);
  end

  // Lowest index wins
  always_comb begin
    grant_d = SRC_MISS;
    for (int i = N_SRC - 1; i >= 0; i--) begin
      if (elig[i]) begin
        grant_d = src_id_e'(i);
      end
    end
    valid_d   = |elig;
    is_read_d = (grant_d == SRC_MISS) & ~i_req[SRC_MISS].data[CMD_WRITE_BIT];
  end

  always_ff @(posedge clk_ni) begin
    if (rst_ni) begin
      valid_q   <= 1'b0;
      grant_q   <= SRC_MISS;
      is_read_q <= 1'b0;
    end else if (i_idle) begin
      valid_q   <= valid_d;
      grant_q   <= grant_d;
      is_read_q <= is_read_d;
    end
  end

  // Live choice while idle, held choice for the rest of the packet
  assign o_grant_valid = i_idle ? valid_d   : valid_q;
  assign o_grant       = i_idle ? grant_d   : grant_q;
  assign o_is_read     = i_idle ? is_read_d : is_read_q;

  // Winning grant starts a packet and is held into it
  a_grant_stable : assert property (
    @(posedge clk_ni) disable iff (rst_ni)
    (i_idle && o_grant_valid) |=> (!i_idle && $stable(o_grant))
  );

endmodule

// ==== design/pkt_fsm.sv ====
`timescale 1ns/1ps

module pkt_fsm
  import mni_pkt_pkg::*;
  import mni_port_pkg::*;
(
  input  logic              clk_ni,
  input  logic              rst_ni,
  input  logic              i_grant_valid,
  input  src_id_e           i_grant,
  input  logic              i_is_read,
  input  logic [WORD_W-1:0] i_cmd,
  input  logic              i_payload_done,
  output pkt_state_e        o_state,
  output logic              o_idle,
  output pkt_desc_t         o_desc,
  output logic              o_advance
);

  pkt_state_e state_d;
  pkt_state_e state_q;
  pkt_desc_t  desc_d;
  pkt_desc_t  desc_q;

  // ====================================================================
  // Next state
  // ====================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (i_grant_valid) begin
          state_d = i_is_read ? RdOpcode : WrOpcode;
        end
      end
      WrOpcode:     state_d = WrDstNode;
      WrDstNode:    state_d = WrDstAdrHigh;
      WrDstAdrHigh: state_d = WrDstAdrLow;
      WrDstAdrLow:  state_d = desc_q.has_ack ? WrAckNode : WrPayload;
      WrAckNode:    state_d = WrAckAdrHigh;
      WrAckAdrHigh: state_d = WrAckAdrLow;
      WrAckAdrLow:  state_d = WrPayload;
      WrPayload: begin
        if (i_payload_done) begin
          state_d = Idle;
        end
      end
      RdOpcode:     state_d = RdDstNode;
      RdDstNode:    state_d = RdDstAdrHigh;
      RdDstAdrHigh: state_d = RdDstAdrLow;
      RdDstAdrLow:  state_d = RdSrcNode;
      RdSrcNode:    state_d = RdSrcAdrHigh;
      RdSrcAdrHigh: state_d = RdSrcAdrLow;
      RdSrcAdrLow:  state_d = RdSizeHigh;
      RdSizeHigh:   state_d = RdSizeLow;
      default:      state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_ni) begin
    if (rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Descriptor from the granted source and its command word
  always_comb begin
    desc_d.kind      = i_is_read ? KIND_READ : KIND_WRITE;
    desc_d.vc        = i_is_read ? VC_READ : (i_grant == SRC_ACK) ? VC_ACK : VC_WRITE;
    desc_d.has_ack   = (i_grant == SRC_WB) |
                       ((i_grant == SRC_MISS) & i_cmd[CMD_WRITE_BIT]);
    desc_d.line_size = (i_grant == SRC_WB) | (i_is_read & i_cmd[CMD_LINE_BIT]);
    desc_d.from_miss = (i_grant == SRC_MISS);
    desc_d.be        = i_cmd[CMD_BE_HI:CMD_BE_LO];
  end

  always_ff @(posedge clk_ni) begin
    if (state_q == Idle && i_grant_valid) begin
      desc_q <= desc_d;
    end
  end

  // States that consume a source word
  always_comb begin
    case (state_q)
      WrDstNode, WrDstAdrHigh, WrDstAdrLow,
      WrAckAdrHigh, WrAckAdrLow, WrPayload,
      RdDstNode, RdDstAdrHigh, RdDstAdrLow,
      RdSrcAdrHigh, RdSrcAdrLow: o_advance = 1'b1;
      default:                   o_advance = 1'b0;
    endcase
  end

  assign o_state = state_q;
  assign o_idle  = (state_q == Idle);
  assign o_desc  = desc_q;

  // No packet runs without a held grant
  a_idle_needs_grant : assert property (
    @(posedge clk_ni) disable iff (rst_ni)
    (state_q != Idle) |-> i_grant_valid
  );

endmodule

// ==== design/word_offset_counter.sv ====
`timescale 1ns/1ps

module word_offset_counter
  import mni_pkt_pkg::*;
(
  input  logic             clk_ni,
  input  logic             rst_ni,
  input  pkt_state_e       i_state,
  input  logic             i_line_size,
  output logic [OFS_W-1:0] o_offset,
  output logic             o_payload_done
);

  localparam logic [OFS_W-1:0] FIRST_OFS      = OFS_W'(PAYLOAD_OFS);
  localparam logic [OFS_W-1:0] LAST_LINE_OFS  = OFS_W'(PAYLOAD_OFS + LINE_WORDS - 1);
  localparam logic [OFS_W-1:0] LAST_SHORT_OFS = OFS_W'(PAYLOAD_OFS + SHORT_WORDS - 1);

  logic [OFS_W-1:0] offset_d;
  logic [OFS_W-1:0] offset_q;
  logic [OFS_W-1:0] last_ofs;

  // Offset of the word built in the current state
  always_comb begin
    case (i_state)
      Idle, WrOpcode, RdOpcode: offset_d = '0;
      // Entry from offset 3 skips the ack slots
      WrPayload: offset_d = (offset_q < FIRST_OFS) ? FIRST_OFS : offset_q + 1'b1;
      default:   offset_d = offset_q + 1'b1;
    endcase
  end

  always_ff @(posedge clk_ni) begin
    if (rst_ni) begin
      offset_q <= '0;
    end else begin
      offset_q <= offset_d;
    end
  end

  assign last_ofs       = i_line_size ? LAST_LINE_OFS : LAST_SHORT_OFS;
  assign o_offset       = offset_d;
  assign o_payload_done = (i_state == WrPayload) && (offset_d == last_ofs);

  a_offset_range : assert property (
    @(posedge clk_ni) disable iff (rst_ni)
    offset_q <= LAST_LINE_OFS
  );

endmodule

// ==== design/pkt_formatter.sv ====
`timescale 1ns/1ps

module pkt_formatter
  import mni_pkt_pkg::*;
  import mni_port_pkg::*;
(
  input  logic              clk_ni,
  input  logic              rst_ni,
  input  pkt_state_e        i_state,
  input  pkt_desc_t         i_desc,
  input  logic [OFS_W-1:0]  i_offset,
  input  logic              i_payload_done,
  input  logic [WORD_W-1:0] i_src_data,
  input  logic [7:0]        i_board_id,
  input  logic [3:0]        i_node_id,
  output nout_word_t        o_word
);

  logic [5:0]        size_code;
  logic [WORD_W-1:0] opcode_word;
  logic [WORD_W-1:0] data_d;
  vc_t               enq_d;
  logic              eop_d;

  vc_t               enq_q;
  logic              eop_q;
  logic [OFS_W-1:0]  offset_q;
  logic [WORD_W-1:0] data_q;

  // ====================================================================
  // Word build
  // ====================================================================
  always_comb begin
    if (i_desc.kind == KIND_READ) begin
      size_code = 6'(RD_SIZE_WORDS);
    end else begin
      size_code = i_desc.line_size ? 6'(LINE_WORDS) : 6'(SHORT_WORDS);
    end
    // Bit 10 flags a non-miss source
    opcode_word = {i_desc.kind, 3'b000, ~i_desc.from_miss, i_desc.has_ack,
                   1'b0, i_desc.vc[2:1], size_code};
  end

  always_comb begin
    data_d = i_src_data;
    case (i_state)
      WrOpcode, RdOpcode:   data_d = opcode_word;
      WrDstNode, RdDstNode: data_d = {i_desc.be, i_board_id, DST_NODE_TAG};
      WrAckNode, RdSrcNode: data_d = {4'h0, i_board_id, i_node_id};
      RdSizeHigh:           data_d = '0;
      RdSizeLow: begin
        data_d = i_desc.line_size ? WORD_W'(LINE_BYTES) : WORD_W'(SHORT_BYTES);
      end
      default: ;
    endcase
  end

  assign enq_d = (i_state != Idle) ? i_desc.vc : '0;
  assign eop_d = ((i_state == WrPayload) && i_payload_done) || (i_state == RdSizeLow);

  // ====================================================================
  // Output register
  // ====================================================================
  always_ff @(posedge clk_ni) begin
    if (rst_ni) begin
      enq_q <= '0;
      eop_q <= 1'b0;
    end else begin
      enq_q <= enq_d;
      eop_q <= eop_d;
    end
  end

  always_ff @(posedge clk_ni) begin
    offset_q <= i_offset;
    data_q   <= data_d;
  end

  assign o_word = '{enq: enq_q, offset: offset_q, eop: eop_q, data: data_q};

endmodule

// ==== design/mni_out.sv ====
`timescale 1ns/1ps

module mni_out
  import mni_pkt_pkg::*;
  import mni_port_pkg::*;
(
  input  logic       clk_ni,
  input  logic       rst_ni,
  input  logic [7:0] i_board_id,
  input  logic [3:0] i_node_id,
  input  src_req_t   i_miss,
  input  src_req_t   i_wb,
  input  src_req_t   i_ack,
  output logic       o_miss_stall,
  output logic       o_wb_stall,
  output logic       o_ack_stall,
  input  vc_t        i_nout_full,
  output nout_word_t o_nout
);

  src_req_t          req [N_SRC];
  logic              grant_valid;
  src_id_e           grant;
  logic              is_read;
  logic              idle;
  logic              advance;
  logic              payload_done;
  pkt_state_e        state;
  pkt_desc_t         desc;
  logic [OFS_W-1:0]  offset;
  logic [WORD_W-1:0] src_data;
  logic [N_SRC-1:0]  stall;

  assign req[SRC_MISS] = i_miss;
  assign req[SRC_WB]   = i_wb;
  assign req[SRC_ACK]  = i_ack;

  // Data of the granted source, the command word while idle
  assign src_data = req[grant].data;

  // ====================================================================
  // Blocks
  // ====================================================================
  src_arbiter u_src_arbiter (
    .clk_ni        (clk_ni),
    .rst_ni        (rst_ni),
    .i_idle        (idle),
    .i_req         (req),
    .i_nout_full   (i_nout_full),
    .o_grant_valid (grant_valid),
    .o_grant       (grant),
    .o_is_read     (is_read)
  );

  pkt_fsm u_pkt_fsm (
    .clk_ni         (clk_ni),
    .rst_ni         (rst_ni),
    .i_grant_valid  (grant_valid),
    .i_grant        (grant),
    .i_is_read      (is_read),
    .i_cmd          (src_data),
    .i_payload_done (payload_done),
    .o_state        (state),
    .o_idle         (idle),
    .o_desc         (desc),
    .o_advance      (advance)
  );

  word_offset_counter u_word_offset_counter (
    .clk_ni         (clk_ni),
    .rst_ni         (rst_ni),
    .i_state        (state),
    .i_line_size    (desc.line_size),
    .o_offset       (offset),
    .o_payload_done (payload_done)
  );

  pkt_formatter u_pkt_formatter (
    .clk_ni         (clk_ni),
    .rst_ni         (rst_ni),
    .i_state        (state),
    .i_desc         (desc),
    .i_offset       (offset),
    .i_payload_done (payload_done),
    .i_src_data     (src_data),
    .i_board_id     (i_board_id),
    .i_node_id      (i_node_id),
    .o_word         (o_nout)
  );

  // Only the granted source sees stall low, and only in an advance state
  always_comb begin
    for (int i = 0; i < N_SRC; i++) begin
      stall[i] = ~(grant_valid & advance & (grant == src_id_e'(i)));
    end
  end

  assign o_miss_stall = stall[SRC_MISS];
  assign o_wb_stall   = stall[SRC_WB];
  assign o_ack_stall  = stall[SRC_ACK];

endmodule

// ==== tests/pkt_model.svh ====
`ifndef PKT_MODEL_SVH
`define PKT_MODEL_SVH

typedef logic [WORD_W-1:0] word_list_t[$];
typedef nout_word_t exp_list_t[$];

function automatic logic [WORD_W-1:0] random_word();
  return WORD_W'($urandom());
endfunction

// Words a packet takes from its source, command word included
function automatic int stream_words(input src_id_e src, input logic [WORD_W-1:0] cmd);
  int n;
  if (src == SRC_MISS && !cmd[CMD_WRITE_BIT]) begin
    // Command, destination address pair, source address pair
    n = 5;
  end else if (src == SRC_WB) begin
    n = 5 + LINE_WORDS;
  end else if (src == SRC_MISS) begin
    n = 5 + SHORT_WORDS;
  end else begin
    // Ack source carries no ack address pair
    n = 3 + SHORT_WORDS;
  end
  return n;
endfunction

function automatic word_list_t make_stream(input src_id_e src, input logic [WORD_W-1:0] cmd);
  word_list_t s;
  s.push_back(cmd);
  for (int i = 1; i < stream_words(src, cmd); i++) begin
    s.push_back(random_word());
  end
  return s;
endfunction

function automatic nout_word_t exp_word(input vc_t vc, input int ofs, input logic eop,
                                        input logic [WORD_W-1:0] data);
  nout_word_t w;
  w.enq    = vc;
  w.offset = OFS_W'(ofs);
  w.eop    = eop;
  w.data   = data;
  return w;
endfunction

// Expected port words of one packet, in output order
function automatic exp_list_t expected_packet(input src_id_e src, input word_list_t s,
                                              input logic [7:0] board, input logic [3:0] node);
  exp_list_t         e;
  logic [WORD_W-1:0] cmd;
  logic [WORD_W-1:0] opc;
  logic [WORD_W-1:0] own_node;
  logic              rd;
  logic              ack_sec;
  logic              line;
  vc_t               vc;
  int                first;
  int                n_pay;
  cmd      = s[0];
  rd       = (src == SRC_MISS) && !cmd[CMD_WRITE_BIT];
  ack_sec  = (src == SRC_WB) || ((src == SRC_MISS) && cmd[CMD_WRITE_BIT]);
  line     = rd ? cmd[CMD_LINE_BIT] : (src == SRC_WB);
  vc       = rd ? 3'b100 : (src == SRC_ACK) ? 3'b001 : 3'b010;
  own_node = {4'h0, board, node};

  opc        = '0;
  opc[15:14] = rd ? 2'b01 : 2'b00;
  opc[10]    = (src != SRC_MISS);
  opc[9]     = ack_sec;
  opc[7:6]   = vc[2:1];
  opc[5:0]   = rd ? 6'd5 : line ? 6'd32 : 6'd2;

  e.push_back(exp_word(vc, 0, 1'b0, opc));
  e.push_back(exp_word(vc, 1, 1'b0, {cmd[CMD_BE_HI:CMD_BE_LO], board, DST_NODE_TAG}));
  e.push_back(exp_word(vc, 2, 1'b0, s[1]));
  e.push_back(exp_word(vc, 3, 1'b0, s[2]));
  if (rd) begin
    e.push_back(exp_word(vc, 4, 1'b0, own_node));
    e.push_back(exp_word(vc, 5, 1'b0, s[3]));
    e.push_back(exp_word(vc, 6, 1'b0, s[4]));
    e.push_back(exp_word(vc, 7, 1'b0, '0));
    e.push_back(exp_word(vc, 8, 1'b1, line ? 16'(LINE_BYTES) : 16'(SHORT_BYTES)));
  end else begin
    first = 3;
    if (ack_sec) begin
      e.push_back(exp_word(vc, 4, 1'b0, own_node));
      e.push_back(exp_word(vc, 5, 1'b0, s[3]));
      e.push_back(exp_word(vc, 6, 1'b0, s[4]));
      first = 5;
    end
    n_pay = s.size() - first;
    for (int i = 0; i < n_pay; i++) begin
      e.push_back(exp_word(vc, PAYLOAD_OFS + i, i == n_pay - 1, s[first + i]));
    end
  end
  return e;
endfunction

`endif

// ==== tests/tb_mni_out.sv ====
`timescale 1ns/1ps

module tb_mni_out
  import mni_pkt_pkg::*;
  import mni_port_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int N_PACKETS    = 14;
  localparam int TIMEOUT      = 200 * N_PACKETS;
  localparam int MEM_DEPTH    = 512;

  `include "pkt_model.svh"

  logic              clk_ni;
  logic              rst_ni;
  logic [7:0]        board_id;
  logic [3:0]        node_id;
  src_req_t          req [N_SRC];
  vc_t               nout_full;
  wire [N_SRC-1:0]   stall;
  nout_word_t        nout;

  // Per-source word store, read and write pointers
  logic [WORD_W-1:0] src_mem [N_SRC][MEM_DEPTH];
  int                wr_ptr [N_SRC];
  int                rd_ptr [N_SRC];
  int                stall_low_cnt [N_SRC];
  exp_list_t         exp_q;
  logic              in_pkt;

  mni_out i_mni_out (
    .clk_ni       (clk_ni),
    .rst_ni       (rst_ni),
    .i_board_id   (board_id),
    .i_node_id    (node_id),
    .i_miss       (req[SRC_MISS]),
    .i_wb         (req[SRC_WB]),
    .i_ack        (req[SRC_ACK]),
    .o_miss_stall (stall[SRC_MISS]),
    .o_wb_stall   (stall[SRC_WB]),
    .o_ack_stall  (stall[SRC_ACK]),
    .i_nout_full  (nout_full),
    .o_nout       (nout)
  );

  initial begin
    clk_ni = 1'b0;
    forever #20 clk_ni = ~clk_ni;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk_ni);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout after %0d cycles, packets did not complete", cycles);
        abort_run();
      end
    end
  end

  // ====================================================================
  // Source models and output comparison
  // ====================================================================
  initial begin : source_models
    for (int s = 0; s < N_SRC; s++) begin
      req[s]           = '0;
      rd_ptr[s]        = 0;
      stall_low_cnt[s] = 0;
    end
    forever begin
      @(posedge clk_ni);
      for (int s = 0; s < N_SRC; s++) begin
        if (!rst_ni && !stall[s]) begin
          stall_low_cnt[s]++;
          if (req[s].valid) begin
            rd_ptr[s]++;
          end
        end
        if (rd_ptr[s] < wr_ptr[s]) begin
          req[s] <= '{valid: 1'b1, data: src_mem[s][rd_ptr[s]]};
        end else begin
          req[s] <= '0;
        end
      end
    end
  end

  initial begin : compare_out
    nout_word_t want;
    in_pkt = 1'b0;
    forever begin
      @(negedge clk_ni);
      if (!rst_ni && nout.enq != '0) begin
        assert (exp_q.size() != 0) else begin
          $display("Output word at %0t while no packet word is expected", $time);
          abort_run();
        end
        want = exp_q.pop_front();
        check_value("o_nout.enq", 32'(nout.enq), 32'(want.enq));
        check_value("o_nout.offset", 32'(nout.offset), 32'(want.offset));
        check_value("o_nout.eop", 32'(nout.eop), 32'(want.eop));
        check_value("o_nout.data", 32'(nout.data), 32'(want.data));
        in_pkt = !nout.eop;
      end else if (!rst_ni) begin
        assert (!in_pkt) else begin
          $display("Gap in the output at %0t before the end of the packet", $time);
          abort_run();
        end
      end
    end
  end

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, want, got);
      abort_run();
    end
  endtask

  task automatic load_stream(input src_id_e src, input word_list_t words);
    foreach (words[i]) begin
      src_mem[src][wr_ptr[src]] = words[i];
      wr_ptr[src]++;
    end
  endtask

  task automatic send_packet(input src_id_e src, input logic [WORD_W-1:0] cmd);
    word_list_t words;
    exp_list_t  pkt;
    words = make_stream(src, cmd);
    pkt   = expected_packet(src, words, board_id, node_id);
    load_stream(src, words);
    foreach (pkt[i]) begin
      exp_q.push_back(pkt[i]);
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0 || in_pkt) begin
      @(posedge clk_ni);
    end
  endtask

  // Every loaded word taken once, one stall-low cycle per word
  task automatic check_sources();
    for (int s = 0; s < N_SRC; s++) begin
      check_value($sformatf("words taken from source %0d", s), rd_ptr[s], wr_ptr[s]);
      check_value($sformatf("stall low cycles of source %0d", s), stall_low_cnt[s],
                  wr_ptr[s]);
    end
  endtask

  task automatic finish_packets();
    wait_drained();
    repeat (2) @(posedge clk_ni);
    @(negedge clk_ni);
    check_sources();
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================
  initial begin : main
    word_list_t        wb_words;
    exp_list_t         wb_expect;
    logic [WORD_W-1:0] cmd;
    src_id_e           src;
    void'($urandom(32'h9924));
    rst_ni    = 1'b1;
    board_id  = 8'hA6;
    node_id   = 4'h3;
    nout_full = '0;
    for (int s = 0; s < N_SRC; s++) begin
      wr_ptr[s] = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk_ni);
    rst_ni <= 1'b0;

    // Quiet port and all sources stalled
    repeat (4) begin
      @(negedge clk_ni);
      check_value("o_nout.enq", 32'(nout.enq), 0);
      check_value("stall", 32'(stall), 32'h7);
    end

    send_packet(SRC_WB, random_word());
    finish_packets();
    send_packet(SRC_ACK, random_word());
    finish_packets();

    // Miss write, then reads of a line and of a short block
    cmd = random_word();
    cmd[CMD_WRITE_BIT] = 1'b1;
    send_packet(SRC_MISS, cmd);
    finish_packets();
    cmd[CMD_WRITE_BIT] = 1'b0;
    cmd[CMD_LINE_BIT]  = 1'b1;
    send_packet(SRC_MISS, cmd);
    finish_packets();
    cmd[CMD_LINE_BIT] = 1'b0;
    send_packet(SRC_MISS, cmd);
    finish_packets();

    // All three requests in the same cycle
    cmd = random_word();
    cmd[CMD_WRITE_BIT] = 1'b1;
    send_packet(SRC_MISS, cmd);
    send_packet(SRC_WB, random_word());
    send_packet(SRC_ACK, random_word());
    finish_packets();

    // VC1 full, so the ack goes first and wb waits
    @(posedge clk_ni);
    nout_full <= VC_WRITE;
    @(negedge clk_ni);
    wb_words  = make_stream(SRC_WB, random_word());
    wb_expect = expected_packet(SRC_WB, wb_words, board_id, node_id);
    load_stream(SRC_WB, wb_words);
    send_packet(SRC_ACK, random_word());
    wait_drained();
    repeat (20) @(posedge clk_ni);
    foreach (wb_expect[i]) begin
      exp_q.push_back(wb_expect[i]);
    end
    nout_full <= '0;
    finish_packets();

    repeat (4) begin
      src = src_id_e'($urandom() % N_SRC);
      send_packet(src, random_word());
      finish_packets();
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+tests
design/mni_pkt_pkg.sv
design/mni_port_pkg.sv
design/src_arbiter.sv
design/pkt_fsm.sv
design/word_offset_counter.sv
design/pkt_formatter.sv
design/mni_out.sv
tests/tb_mni_out.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --assert --top-module tb_mni_out -f filelist.f -o tb_mni_out \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_mni_out > sim.log 2>&1 || true
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
